// File: hdl/qracc_bus_pkg.sv
/* Host bus structs, buffer word types and the controller to datapath bundle.
   Pixels are unsigned bytes in the low byte of a word, weights are signed bytes. */
`default_nettype none

package qracc_bus_pkg;

    import qracc_cfg_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Host strobe bus
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [31:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        rvalid;
    } host_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Buffer words
    ////////////////////////////////////////////////////////////////////////////

    // Output words carry filter 0 in the low byte
    typedef logic [31:0] act_word_t;

    typedef logic signed [7:0] wgt_t;
    typedef wgt_t [NUM_FILTERS-1:0] wgt_word_t;

    // Low 12 bits of a host word
    typedef struct packed {
        logic [3:0] shift;
        logic [7:0] scale;
    } scaler_t;

    // One tap as seen by the datapath
    typedef struct packed {
        logic              tap_valid;
        logic              first_tap;
        logic              last_tap;
        logic [ACT_AW-1:0] pixel_addr;  // Output address of this pixel
    } tap_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/qracc_cfg_pkg.sv
/* Layer shape, controller states and size limits. One input channel, four filters,
   stride 1 with no padding; the host keeps the layer shape stable while busy. */
`default_nettype none

package qracc_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Size limits
    ////////////////////////////////////////////////////////////////////////////

    localparam int MAX_DIM     = 16;
    localparam int MAX_FILTER  = 4;
    localparam int NUM_FILTERS = 4;

    // Input plus output feature maps share one buffer
    localparam int ACT_DEPTH = 512;
    localparam int ACT_AW    = 9;
    localparam int WGT_DEPTH = 16;
    localparam int SCL_DEPTH = 4;

    // Counter and address widths
    localparam int DIM_CW = $clog2(MAX_DIM);
    localparam int FLT_CW = $clog2(MAX_FILTER);
    localparam int WGT_AW = $clog2(WGT_DEPTH);
    localparam int SCL_AW = $clog2(SCL_DEPTH);

    // 16 taps of byte by signed byte need 21 bits, scaling adds 9 more
    localparam int ACC_W    = 24;
    localparam int SCALED_W = ACC_W + 9;

    ////////////////////////////////////////////////////////////////////////////
    // Layer configuration and controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [4:0] ifmap_dimx;   // 1 to 16
        logic [4:0] ifmap_dimy;
        logic [2:0] filter_dimx;  // 1 to 4
        logic [2:0] filter_dimy;
    } conv_cfg_t;

    typedef enum logic [2:0] {
        S_IDLE         = 3'd0,
        S_LOAD_WEIGHTS = 3'd1,
        S_LOAD_ACTS    = 3'd2,
        S_LOAD_SCALERS = 3'd3,
        S_COMPUTE      = 3'd4,
        S_READ_ACTS    = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/qracc_controller.sv
/* Load, compute and readout sequencer for a single-channel direct convolution.
   One tap issues per cycle without stalls; results land in the activation buffer. */
`default_nettype none

module qracc_controller
    import qracc_cfg_pkg::*;
    import qracc_bus_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  logic              start_i,
    input  conv_cfg_t         cfg_i,
    input  host_req_t         host_i,
    input  logic              result_valid_i,
    input  logic [ACT_AW-1:0] result_addr_i,
    input  act_word_t         result_i,
    output logic              act_we_o,
    output logic [ACT_AW-1:0] act_waddr_o,
    output act_word_t         act_wdata_o,
    output logic [ACT_AW-1:0] act_raddr_o,
    output logic              wgt_we_o,
    output logic [WGT_AW-1:0] wgt_addr_o,
    output logic              scl_we_o,
    output logic [SCL_AW-1:0] scl_addr_o,
    output tap_ctrl_t         tap_o,
    output logic              rvalid_o,
    output logic              busy_o,
    output logic              done_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // Layer sizes, all at buffer address width
    logic [ACT_AW-1:0] ifx;
    logic [ACT_AW-1:0] ify;
    logic [ACT_AW-1:0] fdx;
    logic [ACT_AW-1:0] fdy;
    logic [ACT_AW-1:0] ofx;
    logic [ACT_AW-1:0] ofy;
    logic [ACT_AW-1:0] in_size;
    logic [ACT_AW-1:0] out_size;
    logic [ACT_AW-1:0] n_taps;

    // Write pointer in loads, pixel index in compute, read pointer in readout
    logic [ACT_AW-1:0] ptr;
    logic              ptr_step;

    // Convolution window
    logic [FLT_CW-1:0] fx;
    logic [FLT_CW-1:0] fy;
    logic [DIM_CW-1:0] ox;
    logic [DIM_CW-1:0] oy;
    logic [WGT_AW-1:0] tap_idx;
    logic              last_fx;
    logic              last_fy;
    logic              last_ox;
    logic              last_oy;
    logic              all_issued;
    logic              issuing;
    logic [ACT_AW-1:0] tap_raddr;

    // Results issued but not yet written back
    logic [1:0]        pending;
    logic              pix_issued;

    logic              load_wr;
    logic              host_rd;
    logic              last_read;

    assign ifx      = ACT_AW'(cfg_i.ifmap_dimx);
    assign ify      = ACT_AW'(cfg_i.ifmap_dimy);
    assign fdx      = ACT_AW'(cfg_i.filter_dimx);
    assign fdy      = ACT_AW'(cfg_i.filter_dimy);
    assign ofx      = ifx - fdx + 1'b1;
    assign ofy      = ify - fdy + 1'b1;
    assign in_size  = ifx * ify;
    assign out_size = ofx * ofy;
    assign n_taps   = fdx * fdy;

    assign load_wr   = host_i.wr;
    assign host_rd   = (state_q == S_READ_ACTS) && host_i.rd;
    assign last_read = host_rd && (ptr == out_size - 1'b1);

    assign last_fx = ACT_AW'(fx) == fdx - 1'b1;
    assign last_fy = ACT_AW'(fy) == fdy - 1'b1;
    assign last_ox = ACT_AW'(ox) == ofx - 1'b1;
    assign last_oy = ACT_AW'(oy) == ofy - 1'b1;

    assign issuing    = (state_q == S_COMPUTE) && !all_issued;
    assign pix_issued = issuing && last_fx && last_fy;

    // Input pixel under the current tap, row-major
    assign tap_raddr = (ACT_AW'(oy) + ACT_AW'(fy)) * ifx + ACT_AW'(ox) + ACT_AW'(fx);

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d = S_LOAD_WEIGHTS;
                end
            end
            S_LOAD_WEIGHTS: begin
                if (load_wr && ptr == n_taps - 1'b1) begin
                    state_d = S_LOAD_ACTS;
                end
            end
            S_LOAD_ACTS: begin
                if (load_wr && ptr == in_size - 1'b1) begin
                    state_d = S_LOAD_SCALERS;
                end
            end
            S_LOAD_SCALERS: begin
                if (load_wr && ptr == ACT_AW'(NUM_FILTERS - 1)) begin
                    state_d = S_COMPUTE;
                end
            end
            S_COMPUTE: begin
                // Leave only once the final result is in the buffer
                if (all_issued && pending == 2'd0) begin
                    state_d = S_READ_ACTS;
                end
            end
            S_READ_ACTS: begin
                if (last_read) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_comb begin
        case (state_q)
            S_LOAD_WEIGHTS, S_LOAD_ACTS, S_LOAD_SCALERS: ptr_step = load_wr;
            S_COMPUTE:                                   ptr_step = pix_issued;
            S_READ_ACTS:                                 ptr_step = host_rd;
            default:                                     ptr_step = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ptr <= '0;
        end else if (state_d != state_q) begin
            ptr <= '0;
        end else if (ptr_step) begin
            ptr <= ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window counters, filter column innermost
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fx         <= '0;
            fy         <= '0;
            ox         <= '0;
            oy         <= '0;
            tap_idx    <= '0;
            all_issued <= 1'b0;
        end else if (state_q != S_COMPUTE) begin
            fx         <= '0;
            fy         <= '0;
            ox         <= '0;
            oy         <= '0;
            tap_idx    <= '0;
            all_issued <= 1'b0;
        end else if (issuing) begin
            tap_idx <= tap_idx + 1'b1;
            fx      <= fx + 1'b1;
            if (last_fx) begin
                fx <= '0;
                fy <= fy + 1'b1;
                if (last_fy) begin
                    fy      <= '0;
                    tap_idx <= '0;
                    ox      <= ox + 1'b1;
                    if (last_ox) begin
                        ox <= '0;
                        oy <= oy + 1'b1;
                        if (last_oy) begin
                            all_issued <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pending <= 2'd0;
        end else begin
            pending <= pending + {1'b0, pix_issued} - {1'b0, result_valid_i};
        end
    end

    // Flags line up with the registered memory reads
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            tap_o <= '0;
        end else begin
            tap_o.tap_valid  <= issuing;
            tap_o.first_tap  <= (fx == '0) && (fy == '0);
            tap_o.last_tap   <= last_fx && last_fy;
            tap_o.pixel_addr <= in_size + ptr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory ports and host status
    ////////////////////////////////////////////////////////////////////////////

    // Write-back never meets a host load, the states differ
    assign act_we_o    = result_valid_i || (state_q == S_LOAD_ACTS && load_wr);
    assign act_waddr_o = result_valid_i ? result_addr_i : ptr;
    assign act_wdata_o = result_valid_i ? result_i : host_i.wdata;
    assign act_raddr_o = (state_q == S_READ_ACTS) ? in_size + ptr : tap_raddr;

    assign wgt_we_o   = (state_q == S_LOAD_WEIGHTS) && load_wr;
    assign wgt_addr_o = (state_q == S_LOAD_WEIGHTS) ? ptr[WGT_AW-1:0] : tap_idx;
    assign scl_we_o   = (state_q == S_LOAD_SCALERS) && load_wr;
    assign scl_addr_o = ptr[SCL_AW-1:0];

    assign busy_o = state_q != S_IDLE;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rvalid_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            rvalid_o <= host_rd;
            done_o   <= last_read;
        end
    end

endmodule

`default_nettype wire

// File: hdl/qracc_conv_datapath.sv
/* Four filter accumulators with scale, arithmetic shift and clamp to an unsigned byte.
   Accepts a tap every cycle; a result is registered on the last tap of a pixel. */
`default_nettype none

module qracc_conv_datapath
    import qracc_cfg_pkg::*;
    import qracc_bus_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  tap_ctrl_t         tap_i,
    input  act_word_t         act_i,
    input  wgt_word_t         wgt_i,
    input  logic              scl_we_i,
    input  logic [SCL_AW-1:0] scl_addr_i,
    input  scaler_t           scl_i,
    output logic              result_valid_o,
    output act_word_t         result_o,
    output logic [ACT_AW-1:0] result_addr_o
);

    // Per-filter output scalers
    scaler_t [NUM_FILTERS-1:0] scl_q;

    logic signed [ACC_W-1:0]    acc_q   [NUM_FILTERS];
    logic signed [ACC_W-1:0]    prod    [NUM_FILTERS];
    logic signed [ACC_W-1:0]    sum     [NUM_FILTERS];
    logic signed [SCALED_W-1:0] scaled  [NUM_FILTERS];
    logic signed [SCALED_W-1:0] shifted [NUM_FILTERS];
    act_word_t                  res_d;

    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            // Unsigned pixel times signed weight
            prod[f] = $signed({1'b0, act_i[7:0]}) * $signed(wgt_i[f]);
            sum[f]  = tap_i.first_tap ? prod[f] : acc_q[f] + prod[f];

            scaled[f]  = sum[f] * $signed({1'b0, scl_q[f].scale});
            shifted[f] = scaled[f] >>> scl_q[f].shift;

            if (shifted[f] < 0) begin
                res_d[8*f +: 8] = 8'd0;
            end else if (shifted[f] > 255) begin
                res_d[8*f +: 8] = 8'hff;
            end else begin
                res_d[8*f +: 8] = shifted[f][7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scl_we_i) begin
            scl_q[scl_addr_i] <= scl_i;
        end
        if (tap_i.tap_valid) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                acc_q[f] <= sum[f];
            end
        end
        if (tap_i.tap_valid && tap_i.last_tap) begin
            result_o      <= res_d;
            result_addr_o <= tap_i.pixel_addr;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= tap_i.tap_valid && tap_i.last_tap;
        end
    end

endmodule

`default_nettype wire

// File: hdl/qracc_top.sv
/* Convolution accelerator core. Host loads weights, pixels and scalers by strobes,
   then reads outputs back; rdata is valid with rvalid one cycle after rd. */
`default_nettype none

module qracc_top
    import qracc_cfg_pkg::*;
    import qracc_bus_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      start_i,
    input  conv_cfg_t cfg_i,
    input  host_req_t host_i,
    output host_rsp_t host_o,
    output logic      busy_o,
    output logic      done_o
);

    logic              act_we;
    logic [ACT_AW-1:0] act_waddr;
    logic [ACT_AW-1:0] act_raddr;
    act_word_t         act_wdata;
    act_word_t         act_rdata;

    logic              wgt_we;
    logic [WGT_AW-1:0] wgt_addr;
    wgt_word_t         wgt_rdata;

    logic              scl_we;
    logic [SCL_AW-1:0] scl_addr;

    tap_ctrl_t         tap;
    logic              result_valid;
    act_word_t         result;
    logic [ACT_AW-1:0] result_addr;

    qracc_controller u_ctrl (
        .clk            (clk),
        .nrst           (nrst),
        .start_i        (start_i),
        .cfg_i          (cfg_i),
        .host_i         (host_i),
        .result_valid_i (result_valid),
        .result_addr_i  (result_addr),
        .result_i       (result),
        .act_we_o       (act_we),
        .act_waddr_o    (act_waddr),
        .act_wdata_o    (act_wdata),
        .act_raddr_o    (act_raddr),
        .wgt_we_o       (wgt_we),
        .wgt_addr_o     (wgt_addr),
        .scl_we_o       (scl_we),
        .scl_addr_o     (scl_addr),
        .tap_o          (tap),
        .rvalid_o       (host_o.rvalid),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    // Input and output feature maps
    qracc_word_mem #(
        .entry_t (act_word_t),
        .DEPTH   (ACT_DEPTH)
    ) u_act_mem (
        .clk     (clk),
        .we_i    (act_we),
        .waddr_i (act_waddr),
        .raddr_i (act_raddr),
        .wdata_i (act_wdata),
        .rdata_o (act_rdata)
    );

    // One word per tap, one weight per filter
    qracc_word_mem #(
        .entry_t (wgt_word_t),
        .DEPTH   (WGT_DEPTH)
    ) u_wgt_mem (
        .clk     (clk),
        .we_i    (wgt_we),
        .waddr_i (wgt_addr),
        .raddr_i (wgt_addr),
        .wdata_i (host_i.wdata),
        .rdata_o (wgt_rdata)
    );

    qracc_conv_datapath u_dp (
        .clk            (clk),
        .nrst           (nrst),
        .tap_i          (tap),
        .act_i          (act_rdata),
        .wgt_i          (wgt_rdata),
        .scl_we_i       (scl_we),
        .scl_addr_i     (scl_addr),
        .scl_i          (scaler_t'(host_i.wdata[11:0])),
        .result_valid_o (result_valid),
        .result_o       (result),
        .result_addr_o  (result_addr)
    );

    assign host_o.rdata = act_rdata;

endmodule

`default_nettype wire

// File: hdl/qracc_word_mem.sv
/* Simple dual-port memory, one write port and one registered read port.
   A read of the address being written returns the old entry. */
`default_nettype none

module qracc_word_mem #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        // Data appears one cycle after the address
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

// File: qracc.f
hdl/qracc_cfg_pkg.sv
hdl/qracc_bus_pkg.sv
hdl/qracc_word_mem.sv
hdl/qracc_controller.sv
hdl/qracc_conv_datapath.sv
hdl/qracc_top.sv
test/qracc_clkgen.sv
test/qracc_tb.sv

// File: run.sh
#!/bin/sh
# Build the Verilator model from the file list and run it
verilator --binary --timing -Wno-fatal -f qracc.f --top-module qracc_tb -o qracc_sim \
    && ./obj_dir/qracc_sim \
    || exit 1

// File: test/qracc_clkgen.sv
/* Free-running testbench clock, starts low. */
`default_nettype none

module qracc_clkgen #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: test/qracc_tb.sv
/* Random layers from a fixed-seed LFSR, checked against a reference convolution.
   Inputs change 5 units after the rising edge and outputs are sampled there too. */
`default_nettype none

module qracc_tb
    import qracc_cfg_pkg::*;
    import qracc_bus_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          NUM_RANDOM   = 10;
    localparam int          NUM_CLAMP    = 2;
    localparam int          NUM_RUNS     = NUM_RANDOM + NUM_CLAMP;
    // Loads with gaps, worst compute of 2704 taps, readout with gaps
    localparam int          LAYER_CYCLES = 6000;
    localparam int          WATCHDOG     = (16 + NUM_RUNS * LAYER_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'h4a797da2;

    logic      clk;
    logic      nrst;
    logic      start;
    conv_cfg_t cfg;
    host_req_t host_req;
    host_rsp_t host_rsp;
    logic      busy;
    logic      done;

    logic [31:0] lfsr_q;
    int          errors;

    // Current layer and its expected output words
    int          lay_ifx;
    int          lay_ify;
    int          lay_fdx;
    int          lay_fdy;
    logic [7:0]  pix_m [256];
    logic [31:0] wgt_m [16];
    scaler_t     scl_m [NUM_FILTERS];
    act_word_t   exp_out [256];
    int          out_count;
    int          n_read;
    logic        reading;

    qracc_clkgen #(
        .PERIOD (CLK_PERIOD)
    ) u_clkgen (
        .clk_o (clk)
    );

    qracc_top uut (
        .clk     (clk),
        .nrst    (nrst),
        .start_i (start),
        .cfg_i   (cfg),
        .host_i  (host_req),
        .host_o  (host_rsp),
        .busy_o  (busy),
        .done_o  (done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random bits, reporting and the cycle step
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            errors++;
            $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, want);
            stop_run();
        end
    endtask

    // One clock; every response of the readout is checked here
    task automatic tick();
        logic rd_before;
        rd_before = host_req.rd;
        @(posedge clk);
        #5;
        check_eq({31'b0, host_rsp.rvalid && !rd_before}, 0, "rvalid without rd strobe");
        if (reading && rd_before) begin
            check_eq({31'b0, host_rsp.rvalid}, 1, "rvalid one cycle after rd");
        end
        if (host_rsp.rvalid) begin
            check_eq(host_rsp.rdata, exp_out[n_read], $sformatf("output word %0d", n_read));
            n_read++;
            check_eq({31'b0, done}, {31'b0, n_read == out_count}, "done with last read");
            check_eq({31'b0, busy}, {31'b0, n_read != out_count}, "busy during readout");
        end else begin
            check_eq({31'b0, done}, 0, "done without a read");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Layer generation and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Mode 1 forces a 1x1 filter, mode 2 a filter as large as the input
    task automatic random_layer(input int mode);
        lay_fdx = 1 + int'(take_bits(2));
        lay_fdy = 1 + int'(take_bits(2));
        if (mode == 1) begin
            lay_fdx = 1;
            lay_fdy = 1;
        end
        lay_ifx = lay_fdx + int'(take_bits(4)) % (17 - lay_fdx);
        lay_ify = lay_fdy + int'(take_bits(4)) % (17 - lay_fdy);
        if (mode == 2) begin
            lay_ifx = lay_fdx;
            lay_ify = lay_fdy;
        end
        for (int i = 0; i < lay_ifx * lay_ify; i++) begin
            pix_m[i] = 8'(take_bits(8));
        end
        for (int t = 0; t < lay_fdx * lay_fdy; t++) begin
            wgt_m[t] = take_bits(32);
        end
        for (int f = 0; f < NUM_FILTERS; f++) begin
            scl_m[f].scale = 8'(take_bits(8));
            scl_m[f].shift = 4'(take_bits(4));
        end
    endtask

    // Bright pixels; filters 0 and 1 strongly positive, 2 and 3 strongly negative
    task automatic clamp_layer();
        random_layer(0);
        for (int i = 0; i < lay_ifx * lay_ify; i++) begin
            pix_m[i] = 8'(8'd192 + take_bits(6));
        end
        for (int t = 0; t < lay_fdx * lay_fdy; t++) begin
            wgt_m[t][15:0]  = {8'(8'd64 + take_bits(6)), 8'(8'd64 + take_bits(6))};
            wgt_m[t][31:16] = {8'(8'd128 + take_bits(6)), 8'(8'd128 + take_bits(6))};
        end
        for (int f = 0; f < NUM_FILTERS; f++) begin
            scl_m[f].scale = 8'(8'd128 + take_bits(7));
            scl_m[f].shift = 4'(take_bits(2));
        end
    endtask

    task automatic compute_model();
        int          ofx;
        int          ofy;
        longint      acc;
        longint      val;
        logic [31:0] w;
        logic [7:0]  res;
        ofx       = lay_ifx - lay_fdx + 1;
        ofy       = lay_ify - lay_fdy + 1;
        out_count = ofx * ofy;
        for (int oy = 0; oy < ofy; oy++) begin
            for (int ox = 0; ox < ofx; ox++) begin
                for (int f = 0; f < NUM_FILTERS; f++) begin
                    acc = 0;
                    for (int fy = 0; fy < lay_fdy; fy++) begin
                        for (int fx = 0; fx < lay_fdx; fx++) begin
                            w   = wgt_m[fy * lay_fdx + fx];
                            acc += longint'(pix_m[(oy + fy) * lay_ifx + ox + fx])
                                   * longint'($signed(w[8*f +: 8]));
                        end
                    end
                    val = (acc * longint'(scl_m[f].scale)) >>> scl_m[f].shift;
                    if (val < 0) begin
                        res = 8'd0;
                    end else if (val > 255) begin
                        res = 8'hff;
                    end else begin
                        res = 8'(val);
                    end
                    exp_out[oy * ofx + ox][8*f +: 8] = res;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host side of one layer
    ////////////////////////////////////////////////////////////////////////////

    // Random idle gaps and stray reads around each load word
    task automatic host_write(input logic [31:0] data);
        int gap;
        gap = int'(take_bits(2)) % 3;
        repeat (gap) begin
            host_req.rd = (take_bits(1) != 32'd0);
            tick();
            check_eq({31'b0, host_rsp.rvalid}, 0, "rvalid during load");
        end
        host_req.wr    = 1'b1;
        host_req.wdata = data;
        host_req.rd    = (take_bits(1) != 32'd0);
        tick();
        check_eq({31'b0, host_rsp.rvalid}, 0, "rvalid during load");
        host_req.wr = 1'b0;
        host_req.rd = 1'b0;
    endtask

    task automatic run_layer();
        int probes;
        compute_model();
        n_read  = 0;
        reading = 1'b0;

        // Stray writes in idle must not land anywhere
        repeat (2) begin
            host_req.wr    = 1'b1;
            host_req.wdata = take_bits(32);
            tick();
        end
        host_req.wr = 1'b0;
        cfg.ifmap_dimx  = 5'(lay_ifx);
        cfg.ifmap_dimy  = 5'(lay_ify);
        cfg.filter_dimx = 3'(lay_fdx);
        cfg.filter_dimy = 3'(lay_fdy);
        check_eq({31'b0, busy}, 0, "busy before start");

        start = 1'b1;
        tick();
        start = 1'b0;
        check_eq({31'b0, busy}, 1, "busy after start");

        for (int t = 0; t < lay_fdx * lay_fdy; t++) begin
            host_write(wgt_m[t]);
        end
        // Start while busy is ignored
        start = 1'b1;
        tick();
        start = 1'b0;
        check_eq({31'b0, busy}, 1, "busy after start while busy");
        for (int i = 0; i < lay_ifx * lay_ify; i++) begin
            host_write({24'(take_bits(24)), pix_m[i]});
        end
        for (int f = 0; f < NUM_FILTERS; f++) begin
            host_write({20'(take_bits(20)), scl_m[f]});
        end

        // Probe with single reads until the first output comes back
        probes = 0;
        while (n_read == 0) begin
            host_req.rd = 1'b1;
            tick();
            host_req.rd = 1'b0;
            if (n_read == 0) begin
                tick();
                probes++;
                if (probes > LAYER_CYCLES) begin
                    $display("No output word became readable after the loads");
                    stop_run();
                end
            end
        end

        reading = 1'b1;
        while (n_read < out_count) begin
            repeat (int'(take_bits(2)) % 3) begin
                tick();
            end
            host_req.rd = 1'b1;
            tick();
            host_req.rd = 1'b0;
        end
        reading = 1'b0;
        tick();
        check_eq({31'b0, busy}, 0, "busy after readout");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int mode;
        nrst      = 1'b0;
        start     = 1'b0;
        cfg       = '0;
        host_req  = '0;
        lfsr_q    = SEED;
        errors    = 0;
        out_count = 0;
        n_read    = 0;
        reading   = 1'b0;
        repeat (16) begin
            @(posedge clk);
        end
        #5;
        nrst = 1'b1;
        check_eq({31'b0, busy}, 0, "busy after reset");
        check_eq({31'b0, done}, 0, "done after reset");
        check_eq({31'b0, host_rsp.rvalid}, 0, "rvalid after reset");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            mode = (i == 0) ? 1 : (i == 1) ? 2 : 0;
            random_layer(mode);
            run_layer();
        end
        for (int i = 0; i < NUM_CLAMP; i++) begin
            clamp_layer();
            run_layer();
        end

        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_run();
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the layers did not finish in the expected time");
        stop_run();
    end

endmodule

`default_nettype wire
